/* include/tcb_lite_consts.svh */
`ifndef TCB_LITE_CONSTS_SVH
`define TCB_LITE_CONSTS_SVH

// bus widths
`define TCB_ADR_W 16
`define TCB_DAT_W 32
`define TCB_BEN_W 4

// response delay in cycles, only one is supported
`define TCB_DLY 1

// memory subordinate depth in words
`define TCB_MEM_DEPTH 256

// csr offsets within the low address byte
`define TCB_CSR_ID_OFS  8'h00
`define TCB_CSR_SCR_OFS 8'h04
`define TCB_CSR_CNT_OFS 8'h08

// identification word returned by the ID register
`define TCB_SYS_ID 32'h7C81_0A01

`endif

/* src/tcb_lite_pkg.sv */
`include "tcb_lite_consts.svh"

package tcb_lite_pkg;

    ////////////////////
    // response status
    ////////////////////

    // two bit status code
    typedef enum logic [1:0] {
        // transfer completed
        STS_OK     = 2'b00,
        // write to a read-only register
        STS_SLVERR = 2'b10,
        // unmapped offset or misaligned address
        STS_DECERR = 2'b11
    } tcb_sts_t;

    ////////////////////
    // payload types
    ////////////////////

    // one data word
    typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;

    // byte enables, one bit per data byte
    typedef logic [`TCB_BEN_W-1:0] tcb_ben_t;

endpackage

/* src/tcb_lite_map_pkg.sv */
`include "tcb_lite_consts.svh"

package tcb_lite_map_pkg;

    // target of a request
    typedef enum logic [1:0] {
        SEL_MEM  = 2'd0,
        SEL_CSR  = 2'd1,
        // misaligned, answered by the decoder
        SEL_NONE = 2'd2
    } tcb_sel_t;

    // decoded register index
    typedef enum logic [1:0] {
        CSR_ID  = 2'd0,
        CSR_SCR = 2'd1,
        CSR_CNT = 2'd2,
        CSR_BAD = 2'd3
    } csr_idx_t;

    // address map, top bit picks the csr block
    function automatic tcb_sel_t sel_decode(input logic [`TCB_ADR_W-1:0] adr);
        if (adr[1:0] != 2'b00) begin
            return SEL_NONE;
        end
        return adr[`TCB_ADR_W-1] ? SEL_CSR : SEL_MEM;
    endfunction

    // register offset to index
    function automatic csr_idx_t csr_decode(input logic [7:0] ofs);
        case (ofs)
            `TCB_CSR_ID_OFS:  return CSR_ID;
            `TCB_CSR_SCR_OFS: return CSR_SCR;
            `TCB_CSR_CNT_OFS: return CSR_CNT;
            default:          return CSR_BAD;
        endcase
    endfunction

endpackage

/* src/tcb_lite_decoder.sv */
`timescale 1ns/1ps

`include "tcb_lite_consts.svh"

module tcb_lite_decoder (
    input  logic                    sub,
    input  logic                    rst_n,
    // manager side request
    input  logic                    mgr_vld,
    input  logic                    mgr_wen,
    input  logic [`TCB_ADR_W-1:0]   mgr_adr,
    input  tcb_lite_pkg::tcb_ben_t  mgr_ben,
    input  tcb_lite_pkg::tcb_dat_t  mgr_wdt,
    output logic                    mgr_rdy,
    // manager side response
    output tcb_lite_pkg::tcb_dat_t  mgr_rdt,
    output tcb_lite_pkg::tcb_sts_t  mgr_sts,
    output logic                    rsp_vld,
    // memory subordinate
    output logic                    mem_vld,
    input  logic                    mem_rdy,
    input  tcb_lite_pkg::tcb_dat_t  mem_rdt,
    input  tcb_lite_pkg::tcb_sts_t  mem_sts,
    // csr subordinate
    output logic                    csr_vld,
    input  logic                    csr_rdy,
    input  tcb_lite_pkg::tcb_dat_t  csr_rdt,
    input  tcb_lite_pkg::tcb_sts_t  csr_sts,
    // request lines shared by both subordinates
    output logic                    sub_wen,
    output logic [`TCB_ADR_W-1:0]   sub_adr,
    output tcb_lite_pkg::tcb_ben_t  sub_ben,
    output tcb_lite_pkg::tcb_dat_t  sub_wdt
);

    import tcb_lite_pkg::*;
    import tcb_lite_map_pkg::*;

    // target of the current request
    tcb_sel_t sel;
    // target of the transfer whose response is due
    tcb_sel_t sel_q;
    logic     trn;

    ////////////////////
    // request routing
    ////////////////////

    assign sel = sel_decode(mgr_adr);

    // only the selected target sees vld
    assign mem_vld = mgr_vld & (sel == SEL_MEM);
    assign csr_vld = mgr_vld & (sel == SEL_CSR);

    // payload goes to both, vld picks the owner
    assign sub_wen = mgr_wen;
    assign sub_adr = mgr_adr;
    assign sub_ben = mgr_ben;
    assign sub_wdt = mgr_wdt;

    // ready from the addressed target
    always_comb begin
        case (sel)
            SEL_MEM: mgr_rdy = mem_rdy;
            SEL_CSR: mgr_rdy = csr_rdy;
            // misaligned requests never wait
            default: mgr_rdy = 1'b1;
        endcase
    end

    assign trn = mgr_vld & mgr_rdy;

    ////////////////////
    // response steering
    ////////////////////

    // remember where the response will come from
    always_ff @(posedge sub) begin
        if (trn) begin
            sel_q <= sel;
        end
    end

    always_ff @(posedge sub) begin
        if (!rst_n) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= trn;
        end
    end

    always_comb begin
        case (sel_q)
            SEL_MEM: begin
                mgr_rdt = mem_rdt;
                mgr_sts = mem_sts;
            end
            SEL_CSR: begin
                mgr_rdt = csr_rdt;
                mgr_sts = csr_sts;
            end
            // decoder's own error reply
            default: begin
                mgr_rdt = '0;
                mgr_sts = STS_DECERR;
            end
        endcase
    end

    // one owner per request
    a_one_target: assert property (@(posedge sub) disable iff (!rst_n)
        !(mem_vld && csr_vld));

    // every manager transfer gets its response after the bus delay
    a_rsp_follows: assert property (@(posedge sub) disable iff (!rst_n)
        (mgr_vld && mgr_rdy) |-> ##(`TCB_DLY) rsp_vld);

endmodule

/* src/tcb_lite_sub_mem.sv */
`timescale 1ns/1ps

`include "tcb_lite_consts.svh"

module tcb_lite_sub_mem (
    input  logic                    sub,
    input  logic                    rst_n,
    // request
    input  logic                    vld,
    output logic                    rdy,
    input  logic                    wen,
    input  logic [`TCB_ADR_W-1:0]   adr,
    input  tcb_lite_pkg::tcb_ben_t  ben,
    input  tcb_lite_pkg::tcb_dat_t  wdt,
    // response
    output tcb_lite_pkg::tcb_dat_t  rdt,
    output tcb_lite_pkg::tcb_sts_t  sts
);

    import tcb_lite_pkg::*;

    localparam int unsigned MEM_AW = $clog2(`TCB_MEM_DEPTH);

    // word array
    tcb_dat_t           mem [0:`TCB_MEM_DEPTH-1];
    // word index from the byte address
    logic [MEM_AW-1:0]  idx;
    logic               trn;

    assign idx = adr[MEM_AW+1:2];
    assign trn = vld & rdy;

    // no back-pressure, ready right after reset
    always_ff @(posedge sub) begin
        if (!rst_n) begin
            rdy <= 1'b0;
        end else begin
            rdy <= 1'b1;
        end
    end

    ////////////////////
    // write and read
    ////////////////////

    // byte lanes written only where ben is set
    always_ff @(posedge sub) begin
        if (trn && wen) begin
            for (int b = 0; b < `TCB_BEN_W; b++) begin
                if (ben[b]) begin
                    mem[idx][8*b +: 8] <= wdt[8*b +: 8];
                end
            end
        end
    end

    // read data lands one cycle after the transfer
    // writes answer with zero
    always_ff @(posedge sub) begin
        if (trn) begin
            rdt <= wen ? '0 : mem[idx];
        end
    end

    // memory never fails
    assign sts = STS_OK;

    a_adr_known: assert property (@(posedge sub) disable iff (!rst_n)
        (vld && rdy) |-> !$isunknown(adr));

endmodule

/* src/tcb_lite_sub_csr.sv */
`timescale 1ns/1ps

`include "tcb_lite_consts.svh"

module tcb_lite_sub_csr (
    input  logic                    sub,
    input  logic                    rst_n,
    // request
    input  logic                    vld,
    output logic                    rdy,
    input  logic                    wen,
    input  logic [`TCB_ADR_W-1:0]   adr,
    input  tcb_lite_pkg::tcb_ben_t  ben,
    input  tcb_lite_pkg::tcb_dat_t  wdt,
    // response
    output tcb_lite_pkg::tcb_dat_t  rdt,
    output tcb_lite_pkg::tcb_sts_t  sts
);

    import tcb_lite_pkg::*;
    import tcb_lite_map_pkg::*;

    logic     trn;
    // high in the cycle after a transfer, access happens here
    logic     busy;
    // captured request
    csr_idx_t idx_q;
    logic     wen_q;
    tcb_ben_t ben_q;
    tcb_dat_t wdt_q;
    // registers
    tcb_dat_t scr;
    tcb_dat_t cnt;

    assign trn = vld & rdy;

    ////////////////////
    // handshake
    ////////////////////

    // rdy drops for one cycle after each transfer
    always_ff @(posedge sub) begin
        if (!rst_n) begin
            rdy  <= 1'b0;
            busy <= 1'b0;
        end else begin
            rdy  <= ~trn;
            busy <= trn;
        end
    end

    // decode is registered, offset from low byte
    always_ff @(posedge sub) begin
        if (trn) begin
            idx_q <= csr_decode(adr[7:0]);
            wen_q <= wen;
            ben_q <= ben;
            wdt_q <= wdt;
        end
    end

    ////////////////////
    // register access
    ////////////////////

    // scratch, byte-enabled write
    always_ff @(posedge sub) begin
        if (!rst_n) begin
            scr <= '0;
        end else if (busy && wen_q && (idx_q == CSR_SCR)) begin
            for (int b = 0; b < `TCB_BEN_W; b++) begin
                if (ben_q[b]) begin
                    scr[8*b +: 8] <= wdt_q[8*b +: 8];
                end
            end
        end
    end

    // counts every accepted transfer, errors too
    // bumps at the end of the access cycle so a read sees the older count
    always_ff @(posedge sub) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
        end
    end

    // response during the access cycle
    always_comb begin
        rdt = '0;
        sts = STS_OK;
        case (idx_q)
            CSR_ID: begin
                if (wen_q) sts = STS_SLVERR;
                else       rdt = `TCB_SYS_ID;
            end
            CSR_SCR: begin
                if (!wen_q) rdt = scr;
            end
            CSR_CNT: begin
                if (wen_q) sts = STS_SLVERR;
                else       rdt = cnt;
            end
            // unmapped offset
            default: sts = STS_DECERR;
        endcase
    end

    // the access cycle never overlaps a new transfer
    a_no_trn_busy: assert property (@(posedge sub) disable iff (!rst_n)
        (vld && rdy) |=> (busy && !(vld && rdy)));

endmodule

/* src/tcb_lite_sys.sv */
`timescale 1ns/1ps

`include "tcb_lite_consts.svh"

module tcb_lite_sys (
    input  logic                    sub,
    input  logic                    rst_n,
    // manager request
    input  logic                    vld,
    input  logic                    wen,
    input  logic [`TCB_ADR_W-1:0]   adr,
    input  tcb_lite_pkg::tcb_ben_t  ben,
    input  tcb_lite_pkg::tcb_dat_t  wdt,
    output logic                    rdy,
    // manager response
    output tcb_lite_pkg::tcb_dat_t  rdt,
    output tcb_lite_pkg::tcb_sts_t  sts,
    output logic                    rsp_vld
);

    import tcb_lite_pkg::*;

    // subordinate side, shared request
    logic                  sub_wen;
    logic [`TCB_ADR_W-1:0] sub_adr;
    tcb_ben_t              sub_ben;
    tcb_dat_t              sub_wdt;
    // memory segment
    logic                  mem_vld;
    logic                  mem_rdy;
    tcb_dat_t              mem_rdt;
    tcb_sts_t              mem_sts;
    // csr segment
    logic                  csr_vld;
    logic                  csr_rdy;
    tcb_dat_t              csr_rdt;
    tcb_sts_t              csr_sts;

    tcb_lite_decoder u_decoder (
        .sub     (sub),
        .rst_n   (rst_n),
        .mgr_vld (vld),
        .mgr_wen (wen),
        .mgr_adr (adr),
        .mgr_ben (ben),
        .mgr_wdt (wdt),
        .mgr_rdy (rdy),
        .mgr_rdt (rdt),
        .mgr_sts (sts),
        .rsp_vld (rsp_vld),
        .mem_vld (mem_vld),
        .mem_rdy (mem_rdy),
        .mem_rdt (mem_rdt),
        .mem_sts (mem_sts),
        .csr_vld (csr_vld),
        .csr_rdy (csr_rdy),
        .csr_rdt (csr_rdt),
        .csr_sts (csr_sts),
        .sub_wen (sub_wen),
        .sub_adr (sub_adr),
        .sub_ben (sub_ben),
        .sub_wdt (sub_wdt)
    );

    // word memory, lower half of the map
    tcb_lite_sub_mem u_mem (
        .sub   (sub),
        .rst_n (rst_n),
        .vld   (mem_vld),
        .rdy   (mem_rdy),
        .wen   (sub_wen),
        .adr   (sub_adr),
        .ben   (sub_ben),
        .wdt   (sub_wdt),
        .rdt   (mem_rdt),
        .sts   (mem_sts)
    );

    // register block, upper half
    tcb_lite_sub_csr u_csr (
        .sub   (sub),
        .rst_n (rst_n),
        .vld   (csr_vld),
        .rdy   (csr_rdy),
        .wen   (sub_wen),
        .adr   (sub_adr),
        .ben   (sub_ben),
        .wdt   (sub_wdt),
        .rdt   (csr_rdt),
        .sts   (csr_sts)
    );

endmodule

/* test/tcb_lite_sys_tb.sv */
`timescale 1ns/1ps

`include "tcb_lite_consts.svh"

module tcb_lite_sys_tb;

    import tcb_lite_pkg::*;

    localparam int RDY_TIMEOUT = 20;
    localparam int MAX_TESTS   = 40;

    // how the expected read data of an entry is formed
    typedef enum logic [2:0] {
        EXP_MEM, EXP_FIX, EXP_ZERO, EXP_SCR, EXP_CNT
    } exp_mode_t;

    typedef struct packed {
        logic                  wen;
        logic [`TCB_ADR_W-1:0] adr;
        tcb_ben_t              ben;
        tcb_dat_t              wdt;
        // replace wdt with a random word
        logic                  rnd;
        // next entry issued on the response cycle
        logic                  b2b;
        tcb_sts_t              sts;
        exp_mode_t             mode;
        tcb_dat_t              exp_dat;
    } entry_t;

    logic                  sub;
    logic                  rst_n;
    logic                  vld;
    logic                  wen;
    logic [`TCB_ADR_W-1:0] adr;
    tcb_ben_t              ben;
    tcb_dat_t              wdt;
    logic                  rdy;
    tcb_dat_t              rdt;
    tcb_sts_t              sts;
    logic                  rsp_vld;

    entry_t   tbl [0:MAX_TESTS-1];
    int       err_cnt [0:MAX_TESTS-1];
    int       n_tbl;
    int       errors;
    int       tests_failed;
    integer   seed;
    // reference models
    tcb_dat_t ref_mem [0:`TCB_MEM_DEPTH-1];
    tcb_dat_t scr_model;
    tcb_dat_t csr_cnt;
    // response still owed by the DUT
    logic     have_p;
    int       p_idx;
    tcb_dat_t p_rdt;
    tcb_sts_t p_sts;
    logic     p_csr;

    tcb_lite_sys u_tcb_lite_sys (
        .sub     (sub),
        .rst_n   (rst_n),
        .vld     (vld),
        .wen     (wen),
        .adr     (adr),
        .ben     (ben),
        .wdt     (wdt),
        .rdy     (rdy),
        .rdt     (rdt),
        .sts     (sts),
        .rsp_vld (rsp_vld)
    );

    initial begin
        sub = 1'b0;
        forever #20 sub = ~sub;
    end

    ////////////////////
    // helpers
    ////////////////////

    // byte lanes of new replace old where ben is set
    function automatic tcb_dat_t merge_bytes(input tcb_dat_t old, input tcb_dat_t new_dat,
                                             input tcb_ben_t en);
        tcb_dat_t res;
        res = old;
        for (int b = 0; b < `TCB_BEN_W; b++) begin
            if (en[b]) res[8*b +: 8] = new_dat[8*b +: 8];
        end
        return res;
    endfunction

    task automatic add_entry(input logic w, input logic [`TCB_ADR_W-1:0] a, input tcb_ben_t be,
                             input tcb_dat_t d, input logic r, input logic bb,
                             input tcb_sts_t s, input exp_mode_t m, input tcb_dat_t x);
        tbl[n_tbl] = '{w, a, be, d, r, bb, s, m, x};
        err_cnt[n_tbl] = 0;
        n_tbl++;
    endtask

    task automatic note_error(input int idx);
        errors++;
        err_cnt[idx]++;
    endtask

    task automatic fill_table();
        n_tbl = 0;
        // memory, partial byte enables merged into full words
        add_entry(1'b1, 16'h0010, 4'hF, 32'h1122_3344, 1'b0, 1'b0, STS_OK, EXP_ZERO, 32'h0);
        add_entry(1'b1, 16'h0010, 4'h5, 32'hAABB_CCDD, 1'b0, 1'b0, STS_OK, EXP_ZERO, 32'h0);
        add_entry(1'b0, 16'h0010, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_MEM, 32'h0);
        add_entry(1'b1, 16'h0024, 4'hF, 32'h0, 1'b1, 1'b0, STS_OK, EXP_ZERO, 32'h0);
        add_entry(1'b1, 16'h0024, 4'hA, 32'h0, 1'b1, 1'b0, STS_OK, EXP_ZERO, 32'h0);
        add_entry(1'b0, 16'h0024, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_MEM, 32'h0);
        // back-to-back memory chain
        add_entry(1'b1, 16'h0104, 4'hF, 32'h0, 1'b1, 1'b1, STS_OK, EXP_ZERO, 32'h0);
        add_entry(1'b1, 16'h03FC, 4'hF, 32'h0, 1'b1, 1'b1, STS_OK, EXP_ZERO, 32'h0);
        add_entry(1'b0, 16'h0104, 4'hF, 32'h0, 1'b0, 1'b1, STS_OK, EXP_MEM, 32'h0);
        add_entry(1'b1, 16'h0104, 4'h3, 32'h0, 1'b1, 1'b1, STS_OK, EXP_ZERO, 32'h0);
        add_entry(1'b0, 16'h03FC, 4'hF, 32'h0, 1'b0, 1'b1, STS_OK, EXP_MEM, 32'h0);
        add_entry(1'b0, 16'h0104, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_MEM, 32'h0);
        // csr id, count and scratch
        add_entry(1'b0, 16'h8000, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_FIX, `TCB_SYS_ID);
        add_entry(1'b0, 16'h8008, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_CNT, 32'h0);
        add_entry(1'b1, 16'h8004, 4'hF, 32'h1234_5678, 1'b0, 1'b0, STS_OK, EXP_ZERO, 32'h0);
        add_entry(1'b1, 16'h8004, 4'h6, 32'hA5A5_A5A5, 1'b0, 1'b0, STS_OK, EXP_ZERO, 32'h0);
        add_entry(1'b0, 16'h8004, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_SCR, 32'h0);
        // writes to read-only registers
        add_entry(1'b1, 16'h8000, 4'hF, 32'hDEAD_BEEF, 1'b0, 1'b0, STS_SLVERR, EXP_ZERO, 32'h0);
        add_entry(1'b0, 16'h8000, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_FIX, `TCB_SYS_ID);
        add_entry(1'b1, 16'h8008, 4'hF, 32'h0, 1'b1, 1'b0, STS_SLVERR, EXP_ZERO, 32'h0);
        add_entry(1'b0, 16'h8008, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_CNT, 32'h0);
        // unmapped offsets and misaligned addresses
        add_entry(1'b0, 16'h800C, 4'hF, 32'h0, 1'b0, 1'b0, STS_DECERR, EXP_ZERO, 32'h0);
        add_entry(1'b1, 16'h8040, 4'hF, 32'h0, 1'b1, 1'b0, STS_DECERR, EXP_ZERO, 32'h0);
        add_entry(1'b0, 16'h8006, 4'hF, 32'h0, 1'b0, 1'b0, STS_DECERR, EXP_ZERO, 32'h0);
        add_entry(1'b1, 16'h0012, 4'hF, 32'h0, 1'b1, 1'b0, STS_DECERR, EXP_ZERO, 32'h0);
        add_entry(1'b0, 16'h8008, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_CNT, 32'h0);
        add_entry(1'b0, 16'h8004, 4'hF, 32'h0, 1'b0, 1'b0, STS_OK, EXP_SCR, 32'h0);
    endtask

    // called on a falling edge, request fields held until rdy
    task automatic wait_rdy(input int idx, output int waited, output logic ok);
        waited = 0;
        while (rdy !== 1'b1 && waited < RDY_TIMEOUT) begin
            @(negedge sub);
            waited++;
        end
        ok = (rdy === 1'b1);
        if (!ok) begin
            $display("timeout: rdy stayed low for %0d cycles on test %0d", waited, idx);
            note_error(idx);
        end
    endtask

    // expected response from the models, then the models take the transfer
    task automatic record_transfer(input int i, input tcb_dat_t wd);
        logic [7:0] widx;
        logic       mem_hit;
        logic       csr_hit;
        widx    = tbl[i].adr[9:2];
        mem_hit = !tbl[i].adr[`TCB_ADR_W-1] && (tbl[i].adr[1:0] == 2'b00);
        csr_hit = tbl[i].adr[`TCB_ADR_W-1] && (tbl[i].adr[1:0] == 2'b00);
        p_idx   = i;
        p_sts   = tbl[i].sts;
        p_csr   = csr_hit;
        case (tbl[i].mode)
            EXP_MEM: p_rdt = ref_mem[widx];
            EXP_FIX: p_rdt = tbl[i].exp_dat;
            EXP_SCR: p_rdt = scr_model;
            // count of csr transfers before this one
            EXP_CNT: p_rdt = csr_cnt;
            default: p_rdt = '0;
        endcase
        if (mem_hit && tbl[i].wen) begin
            ref_mem[widx] = merge_bytes(ref_mem[widx], wd, tbl[i].ben);
        end
        if (csr_hit) begin
            if (tbl[i].wen && tbl[i].adr[7:0] == `TCB_CSR_SCR_OFS) begin
                scr_model = merge_bytes(scr_model, wd, tbl[i].ben);
            end
            // errors are counted too
            csr_cnt++;
        end
        have_p = 1'b1;
    endtask

    // sampled on the falling edge of the response cycle
    task automatic check_response(input logic chk_rdy_low);
        assert (rsp_vld === 1'b1) else begin
            $display("MISMATCH at %0t: test %0d rsp_vld low after transfer", $time, p_idx);
            note_error(p_idx);
        end
        assert (sts === p_sts) else begin
            $display("MISMATCH at %0t: test %0d sts %0d, expected %0d",
                     $time, p_idx, sts, p_sts);
            note_error(p_idx);
        end
        assert (rdt === p_rdt) else begin
            $display("MISMATCH at %0t: test %0d rdt %h, expected %h",
                     $time, p_idx, rdt, p_rdt);
            note_error(p_idx);
        end
        // csr back-pressure on the cycle after its transfer
        if (chk_rdy_low) begin
            assert (rdy === 1'b0) else begin
                $display("MISMATCH at %0t: test %0d rdy high after csr transfer", $time, p_idx);
                note_error(p_idx);
            end
        end
        if (err_cnt[p_idx] != 0) tests_failed++;
        $display("test %0d %s adr %h: %s", p_idx, tbl[p_idx].wen ? "write" : "read",
                 tbl[p_idx].adr, err_cnt[p_idx] == 0 ? "ok" : "error");
        have_p = 1'b0;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int       waited;
        logic     rdy_ok;
        tcb_dat_t cur_wdt;
        int       reset_err;
        rst_n <= 1'b0;
        vld   <= 1'b0;
        wen   <= 1'b0;
        adr   <= '0;
        ben   <= '0;
        wdt   <= '0;
        seed         = 32'h9838;
        errors       = 0;
        tests_failed = 0;
        scr_model    = '0;
        csr_cnt      = '0;
        have_p       = 1'b0;
        fill_table();

        // reset, nothing valid while it is held
        repeat (5) @(posedge sub);
        rst_n <= 1'b1;
        @(negedge sub);
        reset_err = errors;
        assert (rsp_vld === 1'b0 && rdy === 1'b0) else begin
            $display("MISMATCH at %0t: rsp_vld %b rdy %b during reset", $time, rsp_vld, rdy);
            errors++;
        end
        if (errors != reset_err) tests_failed++;
        $display("test reset: %s", errors == reset_err ? "ok" : "error");
        @(posedge sub);

        for (int i = 0; i < n_tbl; i++) begin
            cur_wdt = tbl[i].rnd ? $random(seed) : tbl[i].wdt;
            vld <= 1'b1;
            wen <= tbl[i].wen;
            adr <= tbl[i].adr;
            ben <= tbl[i].ben;
            wdt <= cur_wdt;
            @(negedge sub);
            // previous back-to-back response, or an idle response line
            if (have_p) begin
                check_response(1'b0);
            end else begin
                assert (rsp_vld === 1'b0) else begin
                    $display("MISMATCH at %0t: rsp_vld high with no transfer", $time);
                    note_error(i);
                end
            end
            wait_rdy(i, waited, rdy_ok);
            if (!rdy_ok) begin
                tests_failed++;
                break;
            end
            // first access right after reset
            if (i == 0) begin
                assert (waited == 0) else begin
                    $display("first memory access had to wait %0d cycles for rdy", waited);
                    note_error(i);
                end
            end
            @(posedge sub);
            record_transfer(i, cur_wdt);
            if (!tbl[i].b2b) begin
                vld <= 1'b0;
                @(negedge sub);
                check_response(p_csr);
                @(posedge sub);
            end
        end

        $display("%0d tests, %0d failed, %0d errors", n_tbl + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
src/tcb_lite_pkg.sv
src/tcb_lite_map_pkg.sv
src/tcb_lite_decoder.sv
src/tcb_lite_sub_mem.sv
src/tcb_lite_sub_csr.sv
src/tcb_lite_sys.sv
test/tcb_lite_sys_tb.sv
